//--- project.f
verilog/wt_cache_pkg.sv
verilog/wt_req_if.sv
verilog/wt_front_end.sv
verilog/wt_buffer.sv
verilog/write_channel_native.sv
verilog/wt_write_path.sv
dv/wt_chk.sv
dv/wt_tb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the write-path testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module wt_tb -f project.f -o wt_sim

./obj_dir/wt_sim

//--- dv/wt_tb.sv
`timescale 1ns/1ps

module wt_tb;

   logic                               clk;
   logic                               reset;
   logic                               req_valid;
   logic [wt_cache_pkg::fe_addr_w-1:0] req_addr;
   logic [wt_cache_pkg::fe_data_w-1:0] req_wdata;
   logic [wt_cache_pkg::fe_nbytes-1:0] req_wstrb;
   logic                               req_ready;
   logic                               mem_valid;
   logic [wt_cache_pkg::be_addr_w-1:0] mem_addr;
   logic [wt_cache_pkg::be_data_w-1:0] mem_wdata;
   logic [wt_cache_pkg::be_nbytes-1:0] mem_wstrb;
   logic                               mem_ready;

   // stimulus table, one index per row
   string                              t_name     [$];
   logic [wt_cache_pkg::fe_addr_w-1:0] t_addr     [$];
   logic [wt_cache_pkg::fe_data_w-1:0] t_wdata    [$];
   logic [wt_cache_pkg::fe_nbytes-1:0] t_wstrb    [$];
   logic [wt_cache_pkg::be_addr_w-1:0] t_exp_addr [$];
   logic [wt_cache_pkg::be_data_w-1:0] t_exp_data [$];
   logic [wt_cache_pkg::be_nbytes-1:0] t_exp_strb [$];
   logic                               t_read     [$];

   int                                 exp_q [$];   // rows owed a back-end write
   int                                 ready_mode;  // 0 random, 1 held low, 2 held high
   int                                 max_wait;
   integer                             seed;
   logic [31:0]                        rnd;
   int                                 mon_idx;
   logic [wt_cache_pkg::be_data_w-1:0] half_mask;

   wt_write_path uut
   (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .req_wstrb (req_wstrb),
      .req_ready (req_ready),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_ready (mem_ready)
   );

   bind wt_write_path wt_chk u_chk
   (
      .clk       (clk),
      .reset     (reset),
      .req_ready (req_ready),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_ready (mem_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // back-end memory model, ready only
   initial
   begin
      mem_ready = 1'b0;
      forever
      begin
         @(posedge clk);
         #1;
         rnd = $random(seed);
         case (ready_mode)
            1:       mem_ready = 1'b0;
            2:       mem_ready = 1'b1;
            default: mem_ready = rnd[0];
         endcase
      end
   end

   task automatic fail_stop(input string what);
      $display("%s", what);
      $display("Simulation failed");
      $fatal(1, "run stopped");
   endtask

   task automatic check_addr(input string name,
                             input logic [wt_cache_pkg::be_addr_w-1:0] exp,
                             input logic [wt_cache_pkg::be_addr_w-1:0] act);
      if (act !== exp)
         fail_stop($sformatf("CHECK FAILED %s: addr expected %h actual %h", name, exp, act));
   endtask

   task automatic check_data(input string name,
                             input logic [wt_cache_pkg::be_data_w-1:0] exp,
                             input logic [wt_cache_pkg::be_data_w-1:0] act);
      if (act !== exp)
         fail_stop($sformatf("CHECK FAILED %s: data expected %h actual %h", name, exp, act));
   endtask

   task automatic check_strb(input string name,
                             input logic [wt_cache_pkg::be_nbytes-1:0] exp,
                             input logic [wt_cache_pkg::be_nbytes-1:0] act);
      if (act !== exp)
         fail_stop($sformatf("CHECK FAILED %s: strobe expected %h actual %h", name, exp, act));
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp)
         fail_stop($sformatf("CHECK FAILED %s: expected %b actual %b", name, exp, act));
   endtask

   task automatic add_row(input string name,
                          input logic [wt_cache_pkg::fe_addr_w-1:0] addr,
                          input logic [wt_cache_pkg::fe_data_w-1:0] wdata,
                          input logic [wt_cache_pkg::fe_nbytes-1:0] wstrb,
                          input logic [wt_cache_pkg::be_addr_w-1:0] exp_addr,
                          input logic [wt_cache_pkg::be_data_w-1:0] exp_data,
                          input logic [wt_cache_pkg::be_nbytes-1:0] exp_strb,
                          input logic is_read);
      t_name.push_back(name);
      t_addr.push_back(addr);
      t_wdata.push_back(wdata);
      t_wstrb.push_back(wstrb);
      t_exp_addr.push_back(exp_addr);
      t_exp_data.push_back(exp_data);
      t_exp_strb.push_back(exp_strb);
      t_read.push_back(is_read);
   endtask

   // byte address = word address * 4, aligned down to 8
   task automatic build_table();
      add_row("even_full", 30'h0000_0010, 32'h1111_2222, 4'hF,
              32'h0000_0040, 64'h0000_0000_1111_2222, 8'h0F, 1'b0);
      add_row("odd_full", 30'h0000_0011, 32'h3333_4444, 4'hF,
              32'h0000_0040, 64'h3333_4444_0000_0000, 8'hF0, 1'b0);
      add_row("even_partial", 30'h0000_0102, 32'hA5A5_5A5A, 4'h5,
              32'h0000_0408, 64'h0000_0000_A5A5_5A5A, 8'h05, 1'b0);
      add_row("read_zero", 30'h0000_0200, 32'hDEAD_BEEF, 4'h0,
              32'h0, 64'h0, 8'h00, 1'b1);
      add_row("odd_partial", 30'h0000_0103, 32'hCAFE_F00D, 4'hA,
              32'h0000_0408, 64'hCAFE_F00D_0000_0000, 8'hA0, 1'b0);
      add_row("odd_top_addr", 30'h3FFF_FFFF, 32'h0123_4567, 4'hC,
              32'hFFFF_FFF8, 64'h0123_4567_0000_0000, 8'hC0, 1'b0);
      add_row("even_high_addr", 30'h2AAA_AAAA, 32'h89AB_CDEF, 4'h3,
              32'hAAAA_AAA8, 64'h0000_0000_89AB_CDEF, 8'h03, 1'b0);
      add_row("read_zero_2", 30'h0000_0001, 32'hFFFF_FFFF, 4'h0,
              32'h0, 64'h0, 8'h00, 1'b1);
      add_row("even_byte0", 30'h0000_0020, 32'h0000_00AB, 4'h1,
              32'h0000_0080, 64'h0000_0000_0000_00AB, 8'h01, 1'b0);
      add_row("odd_byte3", 30'h0000_0021, 32'hAB00_0000, 4'h8,
              32'h0000_0080, 64'hAB00_0000_0000_0000, 8'h80, 1'b0);
      add_row("even_mid", 30'h1234_5678, 32'h5555_AAAA, 4'h6,
              32'h48D1_59E0, 64'h0000_0000_5555_AAAA, 8'h06, 1'b0);
      add_row("odd_mid", 30'h1234_5679, 32'h0F0F_F0F0, 4'hF,
              32'h48D1_59E0, 64'h0F0F_F0F0_0000_0000, 8'hF0, 1'b0);
   endtask

   task automatic drive_row(input int i);
      req_valid = 1'b1;
      req_addr  = t_addr[i];
      req_wdata = t_wdata[i];
      req_wstrb = t_wstrb[i];
   endtask

   // called at the falling edge before the accepting edge
   task automatic finish_accept(input int i);
      if (!t_read[i])
         exp_q.push_back(i);
      @(posedge clk);
      #1;
      req_valid = 1'b0;
   endtask

   task automatic wait_accept(input int i);
      int cnt;
      cnt = 0;
      @(negedge clk);
      while (!req_ready)
      begin
         cnt++;
         if (cnt > max_wait)
            fail_stop($sformatf("req_ready stayed low too long for row %s", t_name[i]));
         @(negedge clk);
      end
      finish_accept(i);
   endtask

   task automatic apply_row(input int i);
      drive_row(i);
      wait_accept(i);
   endtask

   task automatic wait_drain(input string phase);
      int cnt;
      cnt = 0;
      while (exp_q.size() != 0)
      begin
         cnt++;
         if (cnt > max_wait)
            fail_stop($sformatf("back-end writes never completed in %s", phase));
         @(posedge clk);
      end
      @(posedge clk);
      #1;
   endtask

   task automatic set_mode(input int m);
      @(negedge clk);
      ready_mode = m;
      @(posedge clk);
      #1;
   endtask

   // mem_ready low, fill until the processor port stalls
   task automatic stall_fill();
      int  i;
      int  accepted;
      logic stalled;
      i        = 0;
      accepted = 0;
      stalled  = 1'b0;
      while (!stalled && i < t_name.size())
      begin
         if (!t_read[i])
         begin
            drive_row(i);
            @(negedge clk);
            if (req_ready)
            begin
               accepted++;
               finish_accept(i);
            end
            else
               stalled = 1'b1;
         end
         if (!stalled)
            i++;
      end
      if (!stalled)
         fail_stop("req_ready never dropped while mem_ready was held low");
      if (accepted > wt_cache_pkg::buf_depth + 2)
         fail_stop($sformatf("CHECK FAILED backpressure: expected at most %0d writes actual %0d",
                             wt_cache_pkg::buf_depth + 2, accepted));
      ready_mode = 2;                        // release, pending row still driven
      wait_accept(i);
   endtask

   always @(negedge clk)
   begin
      if (!reset && mem_valid && mem_ready)
      begin
         if (exp_q.size() == 0)
            fail_stop("back-end write seen with no write pending");
         else
         begin
            mon_idx = exp_q.pop_front();
            if (t_exp_strb[mon_idx][wt_cache_pkg::be_nbytes-1:wt_cache_pkg::fe_nbytes] != '0)
               half_mask = {{wt_cache_pkg::fe_data_w{1'b1}}, {wt_cache_pkg::fe_data_w{1'b0}}};
            else
               half_mask = {{wt_cache_pkg::fe_data_w{1'b0}}, {wt_cache_pkg::fe_data_w{1'b1}}};
            check_addr(t_name[mon_idx], t_exp_addr[mon_idx], mem_addr);
            check_data(t_name[mon_idx], t_exp_data[mon_idx] & half_mask, mem_wdata & half_mask);
            check_strb(t_name[mon_idx], t_exp_strb[mon_idx], mem_wstrb);
         end
      end
   end

   initial
   begin
      seed       = 77610;
      ready_mode = 2;
      max_wait   = 2000;
      reset      = 1'b1;
      req_valid  = 1'b0;
      req_addr   = '0;
      req_wdata  = '0;
      req_wstrb  = '0;
      build_table();
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      @(negedge clk);
      check_flag("reset req_ready", 1'b1, req_ready);
      check_flag("reset mem_valid", 1'b0, mem_valid);
      @(posedge clk);
      #1;

      for (int i = 0; i < t_name.size(); i++)   // steady mem_ready
         apply_row(i);
      wait_drain("steady phase");

      set_mode(1);
      stall_fill();
      wait_drain("backpressure phase");

      set_mode(0);
      for (int i = 0; i < t_name.size(); i++)   // random mem_ready
         apply_row(i);
      wait_drain("random phase");

      repeat (10) @(posedge clk);                 // no stray writes
      $display("Simulation passed");
      $finish;
   end

endmodule

//--- dv/wt_chk.sv
`timescale 1ns/1ps

module wt_chk
(
   input logic                               clk,
   input logic                               reset,
   input logic                               req_ready,
   input logic                               mem_valid,
   input logic [wt_cache_pkg::be_addr_w-1:0] mem_addr,
   input logic [wt_cache_pkg::be_data_w-1:0] mem_wdata,
   input logic [wt_cache_pkg::be_nbytes-1:0] mem_wstrb,
   input logic                               mem_ready
);

   // back-end request held until mem_ready
   a_mem_hold: assert property (@(posedge clk) disable iff (reset)
      mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) &&
                                  $stable(mem_wdata) && $stable(mem_wstrb))
      else $error("back-end request dropped or changed before mem_ready");

   // zero strobe when idle, never an empty write
   a_mem_strb_live: assert property (@(posedge clk) disable iff (reset)
      mem_valid == (mem_wstrb != '0))
      else $error("mem_wstrb does not match mem_valid");

   // processor stall only behind a pending back-end write
   a_req_stall: assert property (@(posedge clk) disable iff (reset)
      !req_ready |-> mem_valid)
      else $error("req_ready low with no back-end write pending");

endmodule

//--- verilog/wt_write_path.sv
`timescale 1ns/1ps

module wt_write_path
(
   input  logic                              clk,
   input  logic                              reset,

   // processor port
   input  logic                              req_valid,
   input  logic [wt_cache_pkg::fe_addr_w-1:0] req_addr,
   input  logic [wt_cache_pkg::fe_data_w-1:0] req_wdata,
   input  logic [wt_cache_pkg::fe_nbytes-1:0] req_wstrb,
   output logic                              req_ready,

   // back-end port
   output logic                              mem_valid,
   output logic [wt_cache_pkg::be_addr_w-1:0] mem_addr,
   output logic [wt_cache_pkg::be_data_w-1:0] mem_wdata,
   output logic [wt_cache_pkg::be_nbytes-1:0] mem_wstrb,
   input  logic                              mem_ready
);

   wt_req_if fe2buf ();
   wt_req_if buf2wc ();

   wt_front_end u_front
   (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req_addr  (req_addr),
      .req_wdata (req_wdata),
      .req_wstrb (req_wstrb),
      .req_ready (req_ready),
      .out       (fe2buf)
   );

   wt_buffer #(
      .depth (wt_cache_pkg::buf_depth)
   ) u_buf
   (
      .clk   (clk),
      .reset (reset),
      .in    (fe2buf),
      .out   (buf2wc)
   );

   write_channel_native u_wc
   (
      .clk       (clk),
      .reset     (reset),
      .in        (buf2wc),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_ready (mem_ready)
   );

endmodule

//--- verilog/write_channel_native.sv
`timescale 1ns/1ps

module write_channel_native
(
   input  logic                              clk,
   input  logic                              reset,

   wt_req_if.dst                             in,

   output logic                              mem_valid,
   output logic [wt_cache_pkg::be_addr_w-1:0] mem_addr,
   output logic [wt_cache_pkg::be_data_w-1:0] mem_wdata,
   output logic [wt_cache_pkg::be_nbytes-1:0] mem_wstrb,
   input  logic                              mem_ready
);

   typedef enum logic
   {
      st_idle  = 1'b0,
      st_write = 1'b1
   } state_t;

   state_t                  state;
   wt_cache_pkg::wt_entry_t cur;
   logic                    load;
   logic                    word_sel;

   // take a new entry when idle, or as the current one completes
   assign in.ready = (state == st_idle) | mem_ready;
   assign load     = in.valid & in.ready;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state <= st_idle;
      end
      else
      begin
         case (state)
            st_idle:
            begin
               if (in.valid)
                  state <= st_write;
            end
            st_write:
            begin
               if (mem_ready & ~in.valid)
                  state <= st_idle;        // done, nothing queued
            end
            default:
               state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (load)
         cur <= in.entry;
   end

   assign mem_valid = (state == st_write);

   // odd word goes to the upper half of the 64-bit word
   assign word_sel  = cur.addr[0];
   assign mem_addr  = {cur.addr[wt_cache_pkg::fe_addr_w-1:1], 3'b000};
   assign mem_wdata = word_sel ? {cur.wdata, {wt_cache_pkg::fe_data_w{1'b0}}}
                               : {{wt_cache_pkg::fe_data_w{1'b0}}, cur.wdata};

   always_comb
   begin
      mem_wstrb = '0;
      if (mem_valid)
      begin
         if (word_sel)
            mem_wstrb = {cur.wstrb, {wt_cache_pkg::fe_nbytes{1'b0}}};
         else
            mem_wstrb = {{wt_cache_pkg::fe_nbytes{1'b0}}, cur.wstrb};
      end
   end

endmodule

//--- verilog/wt_buffer.sv
`timescale 1ns/1ps

module wt_buffer
#(
   parameter int depth = wt_cache_pkg::buf_depth
)
(
   input  logic  clk,
   input  logic  reset,

   wt_req_if.dst in,
   wt_req_if.src out
);

   localparam int               ptr_w    = (depth > 1) ? $clog2(depth) : 1;
   localparam int               cnt_w    = $clog2(depth + 1);
   localparam logic [ptr_w-1:0] last_ptr = ptr_w'(depth - 1);
   localparam logic [cnt_w-1:0] full_cnt = cnt_w'(depth);

   wt_cache_pkg::wt_entry_t mem [depth];
   logic [ptr_w-1:0]        wr_ptr;
   logic [ptr_w-1:0]        rd_ptr;
   logic [cnt_w-1:0]        count;
   logic                    push;
   logic                    pop;

   // wraps for any depth, not only powers of two
   function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
      if (p == last_ptr)
         return '0;
      else
         return p + 1'b1;
   endfunction

   assign in.ready  = (count != full_cnt);
   assign out.valid = (count != '0);
   assign out.entry = mem[rd_ptr];        // head entry

   assign push = in.valid & in.ready;
   assign pop  = out.valid & out.ready;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop)
            rd_ptr <= next_ptr(rd_ptr);
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;       // idle or push+pop
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= in.entry;
   end

endmodule

//--- verilog/wt_front_end.sv
`timescale 1ns/1ps

module wt_front_end
(
   input  logic                              clk,
   input  logic                              reset,

   input  logic                              req_valid,
   input  logic [wt_cache_pkg::fe_addr_w-1:0] req_addr,
   input  logic [wt_cache_pkg::fe_data_w-1:0] req_wdata,
   input  logic [wt_cache_pkg::fe_nbytes-1:0] req_wstrb,
   output logic                              req_ready,

   wt_req_if.src                             out
);

   logic                    slot_valid;
   wt_cache_pkg::wt_entry_t slot_entry;
   logic                    accept;
   logic                    is_write;

   // slot free now or draining this cycle
   assign req_ready = ~slot_valid | out.ready;
   assign accept    = req_valid & req_ready;
   assign is_write  = |req_wstrb;          // zero strobe means read

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         slot_valid <= 1'b0;
      end
      else if (accept & is_write)
      begin
         slot_valid <= 1'b1;
      end
      else if (out.ready)
      begin
         slot_valid <= 1'b0;                // drained, nothing new
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept & is_write)
      begin
         slot_entry.addr  <= req_addr;
         slot_entry.wdata <= req_wdata;
         slot_entry.wstrb <= req_wstrb;
      end
   end

   assign out.valid = slot_valid;
   assign out.entry = slot_entry;

endmodule

//--- verilog/wt_req_if.sv
`timescale 1ns/1ps

interface wt_req_if;

   logic                    valid;
   logic                    ready;
   wt_cache_pkg::wt_entry_t entry;

   // producer side
   modport src
   (
      output valid,
      output entry,
      input  ready
   );

   // consumer side
   modport dst
   (
      input  valid,
      input  entry,
      output ready
   );

endinterface

//--- verilog/wt_cache_pkg.sv
package wt_cache_pkg;

   // processor side, word addressed
   localparam int fe_addr_w = 30;
   localparam int fe_data_w = 32;
   localparam int fe_nbytes = fe_data_w / 8;

   // back-end side, byte addressed
   localparam int be_addr_w = 32;
   localparam int be_data_w = 64;
   localparam int be_nbytes = be_data_w / 8;

   localparam int buf_depth = 4;       // write-through buffer entries

   // one queued write, 66 bits
   typedef struct packed {
      logic [fe_addr_w-1:0] addr;     // word address
      logic [fe_data_w-1:0] wdata;
      logic [fe_nbytes-1:0] wstrb;
   } wt_entry_t;

endpackage
